// File: hdl/apb_sub_consts.svh
/*
 * Shared widths, slot map and ALUT register offsets for the APB subsystem.
 * Included by the RTL modules and the testbench.
 */
`ifndef APB_SUB_CONSTS_SVH
`define APB_SUB_CONSTS_SVH

// Bus widths
`define DATA_W          32
`define ADDR_W          32

// Five 64 KiB slot windows from SLOT_BASE upward
`define APB_SLOTS       5
`define SLOT_BASE       32'h00A0_0000
`define SLOT_SPAN_BITS  16

// Lookup table geometry
`define ALUT_ENTRIES    8
`define ALUT_IDX_W      3
`define ALUT_PORT_W     2

// ALUT register offsets in the low 4 address bits
`define ALUT_REG_KEY    4'h0
`define ALUT_REG_PORT   4'h4
`define ALUT_REG_CMD    4'h8
`define ALUT_REG_STATUS 4'hC

`endif

// File: hdl/apb_sub_pkg.sv
/*
 * Types shared by the bridge, the ALUT register block and the testbench.
 * Bridge FSM states, ALUT command opcodes and the AHB response code.
 */
package apb_sub_pkg;

   // Bridge FSM, ERR_1/ERR_2 form the two-cycle AHB error response
   typedef enum logic [2:0] {
      IDLE,
      SETUP,
      ACCESS,
      ERR_1,
      ERR_2
   } bridge_state_t;

   // CMD register bits 1:0
   typedef enum logic [1:0] {
      NOP         = 2'd0,
      WRITE_ENTRY = 2'd1,
      LOOKUP      = 2'd2,
      CLEAR       = 2'd3
   } alut_op_t;

   // hresp encoding, only the AHB-Lite subset
   typedef enum logic [1:0] {
      OKAY  = 2'b00,
      ERROR = 2'b01
   } ahb_resp_t;

endpackage

// File: hdl/ahb_apb_bridge.sv
/*
 * AHB-Lite slave to APB master bridge on a single clock.
 * Decodes five APB slots above SLOT_BASE, one psel bit per slot.
 * Unmapped addresses get a two-cycle ERROR response with no APB access.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module ahb_apb_bridge (
   input  logic                                  hclk,
   input  logic                                  arst_n,
   // AHB-Lite slave side
   input  logic                                  hsel,
   input  logic [`ADDR_W-1:0]                    haddr,
   input  logic [1:0]                            htrans,
   input  logic                                  hwrite,
   input  logic [`DATA_W-1:0]                    hwdata,
   input  logic                                  hready_in,
   output logic [`DATA_W-1:0]                    hrdata,
   output logic                                  hready,
   output apb_sub_pkg::ahb_resp_t                hresp,
   // APB master side
   output logic [`ADDR_W-1:0]                    paddr,
   output logic                                  pwrite,
   output logic [`DATA_W-1:0]                    pwdata,
   output logic                                  penable,
   output logic [`APB_SLOTS-1:0]                 psel,
   input  logic [`APB_SLOTS-1:0][`DATA_W-1:0]    prdata,
   input  logic [`APB_SLOTS-1:0]                 pready
);
   import apb_sub_pkg::*;

   localparam int N_SLOT = `APB_SLOTS;
   localparam int SLOT_W = $clog2(N_SLOT);
   localparam int TAG_W  = `ADDR_W - `SLOT_SPAN_BITS;
   localparam logic [TAG_W-1:0] BASE_TAG = TAG_W'(`SLOT_BASE >> `SLOT_SPAN_BITS);

   bridge_state_t         state;
   bridge_state_t         state_nxt;
   logic [`ADDR_W-1:0]    addr_q;
   logic                  write_q;
   logic [SLOT_W-1:0]     slot_q;
   logic [`DATA_W-1:0]    wdata_q;
   logic [`DATA_W-1:0]    rdata_q;
   logic [TAG_W-1:0]      slot_tag;
   logic                  xfer_req;
   logic                  mapped;
   logic                  accept;
   logic                  slot_ready;

   // --------------------------------------------------------------------------
   // Address phase decode
   // --------------------------------------------------------------------------
   // NONSEQ or SEQ, htrans[1] set
   assign xfer_req = hsel && htrans[1] && hready_in;

   // Offset in slot units, wraps high for addresses below the base
   assign slot_tag = haddr[`ADDR_W-1:`SLOT_SPAN_BITS] - BASE_TAG;
   assign mapped   = slot_tag < TAG_W'(N_SLOT);

   // New address phase taken while hready is high
   assign accept   = xfer_req && (state == IDLE || state == ERR_2);

   assign slot_ready = pready[slot_q];

   // --------------------------------------------------------------------------
   // State machine
   // --------------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, ERR_2: begin
            if (xfer_req) begin
               state_nxt = mapped ? SETUP : ERR_1;
            end else begin
               state_nxt = IDLE;
            end
         end
         SETUP:   state_nxt = ACCESS;
         // Stretched for as long as the slave holds pready low
         ACCESS: begin
            if (slot_ready) begin
               state_nxt = IDLE;
            end
         end
         ERR_1:   state_nxt = ERR_2;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Address phase latch
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         addr_q  <= '0;
         write_q <= 1'b0;
         slot_q  <= '0;
      end else if (accept) begin
         addr_q  <= haddr;
         write_q <= hwrite;
         slot_q  <= slot_tag[SLOT_W-1:0];
      end
   end

   // Write data arrives in SETUP, read data taken on the last ACCESS cycle
   always_ff @(posedge hclk) begin
      if (state == SETUP) begin
         wdata_q <= hwdata;
      end
      if (state == ACCESS && slot_ready) begin
         rdata_q <= prdata[slot_q];
      end
   end

   // --------------------------------------------------------------------------
   // Outputs
   // --------------------------------------------------------------------------
   assign hready  = (state == IDLE) || (state == ERR_2);
   assign hresp   = (state == ERR_1 || state == ERR_2) ? ERROR : OKAY;
   assign hrdata  = rdata_q;

   assign paddr   = addr_q;
   assign pwrite  = write_q;
   // hwdata is live during SETUP, held copy afterwards
   assign pwdata  = (state == SETUP) ? hwdata : wdata_q;
   assign penable = (state == ACCESS);
   assign psel    = (state == SETUP || state == ACCESS) ?
                    ({{(N_SLOT-1){1'b0}}, 1'b1} << slot_q) : '0;

   // Every access phase follows a setup cycle to the same slave
   a_penable_after_setup : assert property (@(posedge hclk) disable iff (!arst_n)
      $rose(penable) |-> (psel == $past(psel)) && (|psel));

   // Never more than one slave selected
   a_psel_onehot : assert property (@(posedge hclk) disable iff (!arst_n)
      $onehot0(psel));

endmodule

// File: hdl/alut_regs.sv
/*
 * APB register block of the address lookup table.
 * KEY and PORT hold the operands, CMD writes fire entry strobes or a lookup,
 * STATUS shows the registered lookup result.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module alut_regs (
   input  logic                      hclk,
   input  logic                      arst_n,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [3:0]                paddr,
   input  logic [`DATA_W-1:0]        pwdata,
   output logic [`DATA_W-1:0]        prdata,
   // Table control
   output logic [`ALUT_ENTRIES-1:0]  entry_wr,
   output logic                      entry_clr,
   output logic [`DATA_W-1:0]        key,
   output logic [`ALUT_PORT_W-1:0]   port,
   output logic                      lookup,
   // Registered match result
   input  logic                      match_hit,
   input  logic [`ALUT_IDX_W-1:0]    match_idx,
   input  logic [`ALUT_PORT_W-1:0]   match_port
);
   import apb_sub_pkg::*;

   localparam int N_ENT = `ALUT_ENTRIES;

   logic                    wr_en;
   logic                    cmd_wr;
   alut_op_t                cmd_op;
   logic [`ALUT_IDX_W-1:0]  cmd_idx;

   // Writes act in the APB access cycle
   assign wr_en   = psel && penable && pwrite;
   assign cmd_wr  = wr_en && (paddr == `ALUT_REG_CMD);
   assign cmd_op  = alut_op_t'(pwdata[1:0]);
   assign cmd_idx = pwdata[`ALUT_IDX_W+1:2];

   // Operand registers
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         key  <= '0;
         port <= '0;
      end else if (wr_en) begin
         if (paddr == `ALUT_REG_KEY) begin
            key <= pwdata;
         end
         if (paddr == `ALUT_REG_PORT) begin
            port <= pwdata[`ALUT_PORT_W-1:0];
         end
      end
   end

   // Command strobes, NOP fires nothing
   assign entry_wr  = (cmd_wr && cmd_op == WRITE_ENTRY) ?
                      ({{(N_ENT-1){1'b0}}, 1'b1} << cmd_idx) : '0;
   assign entry_clr = cmd_wr && (cmd_op == CLEAR);
   assign lookup    = cmd_wr && (cmd_op == LOOKUP);

   // Read mux, CMD reads back zero
   always_comb begin
      prdata = '0;
      case (paddr)
         `ALUT_REG_KEY:  prdata = key;
         `ALUT_REG_PORT: prdata[`ALUT_PORT_W-1:0] = port;
         `ALUT_REG_STATUS: begin
            prdata[0]                  = match_hit;
            prdata[4 +: `ALUT_PORT_W]  = match_port;
            prdata[8 +: `ALUT_IDX_W]   = match_idx;
         end
         default: prdata = '0;
      endcase
   end

   // One entry written per command at most
   a_entry_wr_onehot : assert property (@(posedge hclk) disable iff (!arst_n)
      $onehot0(entry_wr));

endmodule

// File: hdl/alut_entry.sv
/*
 * One lookup table entry with valid flag, stored key and egress port.
 * Comparison against the lookup key is purely combinational.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module alut_entry (
   input  logic                     hclk,
   input  logic                     arst_n,
   input  logic                     wr,
   input  logic                     clr,
   input  logic [`DATA_W-1:0]       key_in,
   input  logic [`ALUT_PORT_W-1:0]  port_in,
   input  logic [`DATA_W-1:0]       lookup_key,
   output logic                     hit,
   output logic [`ALUT_PORT_W-1:0]  port
);

   logic                     valid;
   logic [`DATA_W-1:0]       key_q;

   // Clear takes priority over a write
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         valid <= 1'b0;
      end else if (clr) begin
         valid <= 1'b0;
      end else if (wr) begin
         valid <= 1'b1;
      end
   end

   // Stored contents
   always_ff @(posedge hclk) begin
      if (wr) begin
         key_q <= key_in;
         port  <= port_in;
      end
   end

   assign hit = valid && (key_q == lookup_key);

endmodule

// File: hdl/alut_match.sv
/*
 * Priority select over all table entry hits.
 * Lowest index wins; result registered on the lookup strobe.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module alut_match (
   input  logic                                        hclk,
   input  logic                                        arst_n,
   input  logic                                        lookup,
   input  logic [`ALUT_ENTRIES-1:0]                    hits,
   input  logic [`ALUT_ENTRIES-1:0][`ALUT_PORT_W-1:0]  ports,
   output logic                                        match_hit,
   output logic [`ALUT_IDX_W-1:0]                      match_idx,
   output logic [`ALUT_PORT_W-1:0]                     match_port
);

   localparam int N_ENT = `ALUT_ENTRIES;
   localparam int IDX_W = `ALUT_IDX_W;

   logic                     any_hit;
   logic [IDX_W-1:0]         sel_idx;
   logic [`ALUT_PORT_W-1:0]  sel_port;

   // Scan downward so the lowest hit is the last one kept
   always_comb begin
      any_hit  = 1'b0;
      sel_idx  = '0;
      sel_port = '0;
      for (int i = N_ENT - 1; i >= 0; i--) begin
         if (hits[i]) begin
            any_hit  = 1'b1;
            sel_idx  = IDX_W'(i);
            sel_port = ports[i];
         end
      end
   end

   // Miss reads as hit, index and port all zero
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         match_hit  <= 1'b0;
         match_idx  <= '0;
         match_port <= '0;
      end else if (lookup) begin
         match_hit  <= any_hit;
         match_idx  <= sel_idx;
         match_port <= sel_port;
      end
   end

endmodule

// File: hdl/apb_subsystem.sv
/*
 * APB peripheral subsystem on an AHB-Lite bus.
 * Slot 0 is the address lookup table, slots 1 to 4 the four MAC register ports.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module apb_subsystem (
   // AHB-Lite
   input  logic                    hclk,
   input  logic                    arst_n,
   input  logic                    hsel,
   input  logic [`ADDR_W-1:0]      haddr,
   input  logic [1:0]              htrans,
   input  logic                    hwrite,
   input  logic [`DATA_W-1:0]      hwdata,
   input  logic                    hready_in,
   output logic [`DATA_W-1:0]      hrdata,
   output logic                    hready,
   output apb_sub_pkg::ahb_resp_t  hresp,
   // Shared APB
   output logic [`ADDR_W-1:0]      paddr,
   output logic                    pwrite,
   output logic                    penable,
   output logic [`DATA_W-1:0]      pwdata,
   // MAC ports
   output logic                    psel_mac0,
   output logic                    psel_mac1,
   output logic                    psel_mac2,
   output logic                    psel_mac3,
   input  logic [`DATA_W-1:0]      prdata_mac0,
   input  logic [`DATA_W-1:0]      prdata_mac1,
   input  logic [`DATA_W-1:0]      prdata_mac2,
   input  logic [`DATA_W-1:0]      prdata_mac3,
   input  logic                    pready_mac0,
   input  logic                    pready_mac1,
   input  logic                    pready_mac2,
   input  logic                    pready_mac3
);

   logic                                        psel_alut;
   logic [`DATA_W-1:0]                          prdata_alut;
   logic [`ALUT_ENTRIES-1:0]                    entry_wr;
   logic                                        entry_clr;
   logic [`DATA_W-1:0]                          key;
   logic [`ALUT_PORT_W-1:0]                     port;
   logic                                        lookup;
   logic [`ALUT_ENTRIES-1:0]                    hits;
   logic [`ALUT_ENTRIES-1:0][`ALUT_PORT_W-1:0]  ports;
   logic                                        match_hit;
   logic [`ALUT_IDX_W-1:0]                      match_idx;
   logic [`ALUT_PORT_W-1:0]                     match_port;

   // --------------------------------------------------------------------------
   // Bridge, slot 0 ALUT, slots 1-4 MAC0-MAC3
   // --------------------------------------------------------------------------
   ahb_apb_bridge i_ahb_apb_bridge (
      .hclk      (hclk),
      .arst_n    (arst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .paddr     (paddr),
      .pwrite    (pwrite),
      .pwdata    (pwdata),
      .penable   (penable),
      .psel      ({psel_mac3, psel_mac2, psel_mac1, psel_mac0, psel_alut}),
      .prdata    ({prdata_mac3, prdata_mac2, prdata_mac1, prdata_mac0, prdata_alut}),
      // ALUT never inserts wait states
      .pready    ({pready_mac3, pready_mac2, pready_mac1, pready_mac0, 1'b1})
   );

   // --------------------------------------------------------------------------
   // Lookup table
   // --------------------------------------------------------------------------
   alut_regs i_alut_regs (
      .hclk       (hclk),
      .arst_n     (arst_n),
      .psel       (psel_alut),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr[3:0]),
      .pwdata     (pwdata),
      .prdata     (prdata_alut),
      .entry_wr   (entry_wr),
      .entry_clr  (entry_clr),
      .key        (key),
      .port       (port),
      .lookup     (lookup),
      .match_hit  (match_hit),
      .match_idx  (match_idx),
      .match_port (match_port)
   );

   // KEY register is both the write operand and the lookup key
   for (genvar g = 0; g < `ALUT_ENTRIES; g++) begin : g_entry
      alut_entry i_alut_entry (
         .hclk       (hclk),
         .arst_n     (arst_n),
         .wr         (entry_wr[g]),
         .clr        (entry_clr),
         .key_in     (key),
         .port_in    (port),
         .lookup_key (key),
         .hit        (hits[g]),
         .port       (ports[g])
      );
   end

   alut_match i_alut_match (
      .hclk       (hclk),
      .arst_n     (arst_n),
      .lookup     (lookup),
      .hits       (hits),
      .ports      (ports),
      .match_hit  (match_hit),
      .match_idx  (match_idx),
      .match_port (match_port)
   );

endmodule

// File: verification/mac_apb_model.sv
/*
 * Behavioral APB slave standing in for one MAC register port.
 * Four word registers at offsets 0x0 to 0xC, 0 to 3 random wait states per access.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module mac_apb_model (
   input  logic               hclk,
   input  logic               arst_n,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [3:0]         paddr,
   input  logic [`DATA_W-1:0] pwdata,
   output logic [`DATA_W-1:0] prdata,
   output logic               pready
);

   integer              seed = 35;
   integer              rnd;
   logic [1:0]          wait_cnt;
   logic [`DATA_W-1:0]  regs [4];

   // Wait count drawn in SETUP, counted down through ACCESS
   always @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         wait_cnt <= 2'd0;
      end else if (psel && !penable) begin
         rnd = $random(seed);
         wait_cnt <= rnd[1:0];
      end else if (psel && penable && wait_cnt != 2'd0) begin
         wait_cnt <= wait_cnt - 2'd1;
      end
   end

   assign pready = psel && penable && (wait_cnt == 2'd0);

   // Register file, written on the completing ACCESS cycle
   always @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 4; i++) begin
            regs[i] <= '0;
         end
      end else if (psel && penable && pwrite && pready) begin
         regs[paddr[3:2]] <= pwdata;
      end
   end

   // Word select from offset bits 3:2
   assign prdata = regs[paddr[3:2]];

endmodule

// File: verification/tb_apb_subsystem.sv
/*
 * Directed testbench for the APB subsystem.
 * Drives AHB-Lite transfers into the DUT with four behavioral MAC slaves on the
 * APB side; checks MAC access, unmapped decode and ALUT lookups.
 */
`timescale 1ns/10ps
`include "apb_sub_consts.svh"

module tb_apb_subsystem;
   import apb_sub_pkg::*;

   localparam int CLK_PERIOD = 10;
   // 1 reset + 35 MAC + 6 unmapped + 21 lookup + 19 priority transfers
   localparam int N_XFERS = 82;
   localparam int WATCHDOG_CYCLES = N_XFERS * 10 + 100;

   logic                hclk;
   logic                arst_n;
   logic                hsel;
   logic [`ADDR_W-1:0]  haddr;
   logic [1:0]          htrans;
   logic                hwrite;
   logic [`DATA_W-1:0]  hwdata;
   logic                hready_in;
   logic [`DATA_W-1:0]  hrdata;
   logic                hready;
   ahb_resp_t           hresp;
   logic [`ADDR_W-1:0]  paddr;
   logic                pwrite;
   logic                penable;
   logic [`DATA_W-1:0]  pwdata;
   logic [3:0]          psel_mac;
   logic [3:0]          pready_mac;
   logic [`DATA_W-1:0]  prdata_mac [4];

   int                  errors_data = 0;
   int                  errors_resp = 0;
   int                  errors_other = 0;
   int                  psel_mac_cycles = 0;
   logic [`DATA_W-1:0]  mac_shadow [4][4];
   // Result of the most recent AHB transfer
   logic [`DATA_W-1:0]  last_rdata;
   ahb_resp_t           last_resp;
   ahb_resp_t           last_low_resp;
   int                  last_low_cycles;

   // -------------------------------------------------------------------------
   // DUT and MAC slaves
   // -------------------------------------------------------------------------
   apb_subsystem i_apb_subsystem (
      .hclk        (hclk),
      .arst_n      (arst_n),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .penable     (penable),
      .pwdata      (pwdata),
      .psel_mac0   (psel_mac[0]),
      .psel_mac1   (psel_mac[1]),
      .psel_mac2   (psel_mac[2]),
      .psel_mac3   (psel_mac[3]),
      .prdata_mac0 (prdata_mac[0]),
      .prdata_mac1 (prdata_mac[1]),
      .prdata_mac2 (prdata_mac[2]),
      .prdata_mac3 (prdata_mac[3]),
      .pready_mac0 (pready_mac[0]),
      .pready_mac1 (pready_mac[1]),
      .pready_mac2 (pready_mac[2]),
      .pready_mac3 (pready_mac[3])
   );

   for (genvar m = 0; m < 4; m++) begin : g_mac
      mac_apb_model i_mac_apb_model (
         .hclk    (hclk),
         .arst_n  (arst_n),
         .psel    (psel_mac[m]),
         .penable (penable),
         .pwrite  (pwrite),
         .paddr   (paddr[3:0]),
         .pwdata  (pwdata),
         .prdata  (prdata_mac[m]),
         .pready  (pready_mac[m])
      );
   end

   initial begin
      hclk = 1'b0;
      forever #(CLK_PERIOD / 2) hclk = ~hclk;
   end

   // Counts cycles with any MAC selected
   always @(posedge hclk) begin
      if (|psel_mac) begin
         psel_mac_cycles <= psel_mac_cycles + 1;
      end
   end

   // -------------------------------------------------------------------------
   // Compare tasks and address helpers
   // -------------------------------------------------------------------------
   task automatic check_data(input string test, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         errors_data++;
         $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, exp, act);
      end
   endtask

   task automatic check_resp(input string test, input ahb_resp_t exp, input ahb_resp_t act);
      if (exp !== act) begin
         errors_resp++;
         $display("[ERROR] %s: expected %s, actual %s", test, exp.name(), act.name());
      end
   endtask

   task automatic report_failure(input string what);
      errors_other++;
      $display("Failure: %s", what);
   endtask

   function automatic logic [31:0] slot_addr(input int slot, input logic [3:0] off);
      return `SLOT_BASE + (32'(slot) << `SLOT_SPAN_BITS) + 32'(off);
   endfunction

   // MAC m sits in slot m+1
   function automatic logic [31:0] mac_addr(input int m, input int r);
      return slot_addr(m + 1, 4'(r * 4));
   endfunction

   // Opcode in CMD bits 1:0 and entry index in bits 4:2
   function automatic logic [31:0] cmd_word(input alut_op_t op, input int idx);
      return (32'(idx) << 2) | 32'(op);
   endfunction

   // STATUS holds hit in bit 0, port in 5:4 and index in 10:8
   function automatic logic [31:0] status_word(input logic hit, input logic [1:0] port,
                                               input int idx);
      return 32'(hit) | (32'(port) << 4) | (32'(idx) << 8);
   endfunction

   // -------------------------------------------------------------------------
   // AHB driver
   // -------------------------------------------------------------------------
   task automatic ahb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata);
      @(posedge hclk);
      #1;
      hsel   = 1'b1;
      haddr  = addr;
      htrans = 2'b10;
      hwrite = write;
      // Data phase begins after the edge that takes the address
      @(posedge hclk);
      #1;
      hsel   = 1'b0;
      htrans = 2'b00;
      hwdata = wdata;
      last_low_cycles = 0;
      last_low_resp   = OKAY;
      @(negedge hclk);
      while (!hready) begin
         last_low_cycles++;
         last_low_resp = hresp;
         @(negedge hclk);
      end
      last_rdata = hrdata;
      last_resp  = hresp;
   endtask

   task automatic ahb_write(input string test, input logic [31:0] addr,
                            input logic [31:0] data, input ahb_resp_t exp_resp);
      ahb_transfer(1'b1, addr, data);
      check_resp(test, exp_resp, last_resp);
   endtask

   task automatic ahb_read(input string test, input logic [31:0] addr,
                           input ahb_resp_t exp_resp, output logic [31:0] data);
      ahb_transfer(1'b0, addr, 32'd0);
      check_resp(test, exp_resp, last_resp);
      data = last_rdata;
   endtask

   // Three register writes per table entry
   task automatic alut_write_entry(input string test, input logic [31:0] key,
                                   input logic [1:0] port, input int idx);
      ahb_write(test, slot_addr(0, `ALUT_REG_KEY), key, OKAY);
      ahb_write(test, slot_addr(0, `ALUT_REG_PORT), 32'(port), OKAY);
      ahb_write(test, slot_addr(0, `ALUT_REG_CMD), cmd_word(WRITE_ENTRY, idx), OKAY);
   endtask

   task automatic alut_lookup(input string test, input logic [31:0] key,
                              input logic [31:0] exp_status);
      logic [31:0] rd;
      ahb_write(test, slot_addr(0, `ALUT_REG_KEY), key, OKAY);
      ahb_write(test, slot_addr(0, `ALUT_REG_CMD), cmd_word(LOOKUP, 0), OKAY);
      ahb_read(test, slot_addr(0, `ALUT_REG_STATUS), OKAY, rd);
      check_data(test, exp_status, rd);
   endtask

   // -------------------------------------------------------------------------
   // Directed tests
   // -------------------------------------------------------------------------
   task automatic reset_defaults();
      logic [31:0] rd;
      check_data("reset hready", 32'd1, 32'(hready));
      check_resp("reset hresp", OKAY, hresp);
      check_data("reset psel_mac", 32'd0, 32'(psel_mac));
      check_data("reset penable", 32'd0, 32'(penable));
      ahb_read("reset status", slot_addr(0, `ALUT_REG_STATUS), OKAY, rd);
      check_data("reset status", 32'd0, rd);
      // ALUT never stretches ACCESS
      check_data("alut wait cycles", 32'd2, last_low_cycles);
   endtask

   task automatic mac_round_trip();
      logic [31:0] rd;
      for (int m = 0; m < 4; m++) begin
         for (int r = 0; r < 4; r++) begin
            mac_shadow[m][r] = {16'hCAFE, 4'(m), 4'(r), 8'h5A};
            ahb_write($sformatf("mac%0d reg%0d write", m, r), mac_addr(m, r),
                      mac_shadow[m][r], OKAY);
         end
      end
      // Reading all back also shows slots are isolated
      for (int m = 0; m < 4; m++) begin
         for (int r = 0; r < 4; r++) begin
            ahb_read($sformatf("mac%0d reg%0d read", m, r), mac_addr(m, r), OKAY, rd);
            check_data($sformatf("mac%0d reg%0d read", m, r), mac_shadow[m][r], rd);
         end
      end
      mac_shadow[1][0] = 32'h1234_5678;
      ahb_write("mac1 rewrite", mac_addr(1, 0), mac_shadow[1][0], OKAY);
      ahb_read("mac2 untouched", mac_addr(2, 0), OKAY, rd);
      check_data("mac2 untouched", mac_shadow[2][0], rd);
      ahb_read("mac1 rewrite", mac_addr(1, 0), OKAY, rd);
      check_data("mac1 rewrite", mac_shadow[1][0], rd);
   endtask

   task automatic unmapped_error();
      logic [31:0] rd;
      int          psel_before;
      psel_before = psel_mac_cycles;
      ahb_write("unmapped write", slot_addr(5, 4'h0), 32'hBAD0_0001, ERROR);
      check_resp("unmapped write first cycle", ERROR, last_low_resp);
      check_data("unmapped write low cycles", 32'd1, last_low_cycles);
      ahb_read("unmapped read", slot_addr(5, 4'h0), ERROR, rd);
      check_resp("unmapped read first cycle", ERROR, last_low_resp);
      check_data("unmapped read low cycles", 32'd1, last_low_cycles);
      if (psel_mac_cycles != psel_before) begin
         report_failure("a MAC psel rose during an unmapped access");
      end
      for (int m = 0; m < 4; m++) begin
         ahb_read($sformatf("mac%0d after unmapped", m), mac_addr(m, 0), OKAY, rd);
         check_data($sformatf("mac%0d after unmapped", m), mac_shadow[m][0], rd);
      end
   endtask

   task automatic table_lookups();
      alut_write_entry("lookup fill", 32'h1111_0001, 2'd2, 1);
      alut_write_entry("lookup fill", 32'hDEAD_BEEF, 2'd1, 4);
      alut_write_entry("lookup fill", 32'h0000_0042, 2'd3, 7);
      alut_lookup("lookup idx1", 32'h1111_0001, status_word(1'b1, 2'd2, 1));
      alut_lookup("lookup idx4", 32'hDEAD_BEEF, status_word(1'b1, 2'd1, 4));
      alut_lookup("lookup idx7", 32'h0000_0042, status_word(1'b1, 2'd3, 7));
      alut_lookup("lookup miss", 32'h7777_7777, 32'd0);
   endtask

   task automatic priority_and_clear();
      alut_write_entry("priority fill", 32'h5A5A_0606, 2'd1, 6);
      alut_write_entry("priority fill", 32'h5A5A_0606, 2'd3, 2);
      // Lowest index wins
      alut_lookup("priority", 32'h5A5A_0606, status_word(1'b1, 2'd3, 2));
      ahb_write("clear", slot_addr(0, `ALUT_REG_CMD), cmd_word(CLEAR, 0), OKAY);
      alut_lookup("after clear", 32'h5A5A_0606, 32'd0);
      alut_write_entry("rewrite idx2", 32'h5A5A_0606, 2'd3, 2);
      alut_lookup("after rewrite", 32'h5A5A_0606, status_word(1'b1, 2'd3, 2));
   endtask

   // -------------------------------------------------------------------------
   // Sequence, watchdog and summary
   // -------------------------------------------------------------------------
   initial begin : watchdog
      bridge_state_t st;
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      st = i_apb_subsystem.i_ahb_apb_bridge.state;
      $display("Timeout after %0d cycles, the bridge is stuck in state %s",
               WATCHDOG_CYCLES, st.name());
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      hsel      = 1'b0;
      haddr     = '0;
      htrans    = 2'b00;
      hwrite    = 1'b0;
      hwdata    = '0;
      hready_in = 1'b1;
      arst_n    = 1'b0;
      repeat (2) @(posedge hclk);
      #1;
      arst_n = 1'b1;

      reset_defaults();
      mac_round_trip();
      unmapped_error();
      table_lookups();
      priority_and_clear();

      @(posedge hclk);
      $display("Errors: %0d data, %0d response, %0d other",
               errors_data, errors_resp, errors_other);
      if (errors_data + errors_resp + errors_other == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+hdl
hdl/apb_sub_pkg.sv
hdl/ahb_apb_bridge.sv
hdl/alut_regs.sv
hdl/alut_entry.sv
hdl/alut_match.sv
hdl/apb_subsystem.sv
verification/mac_apb_model.sv
verification/tb_apb_subsystem.sv

// File: Makefile
# Verilator build and run for the APB subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_subsystem
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FLIST) --Mdir $(OBJ_DIR) -o V$*

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
